// File: source/spectrum_pkg.sv
/*
 * spectrum column server shared definitions
 * frame sizes, sample and column structs, FSM state encodings
 */
`default_nettype none

package spectrum_pkg;

    //******************************************************************
    //  sizes
    //******************************************************************
    localparam int FFT_LENGTH = 256;            // samples per fft frame
    localparam int HALF_BINS  = FFT_LENGTH / 2; // real input, upper half mirrors lower
    localparam int BIN_IDX_W  = $clog2(HALF_BINS);
    localparam int MAG_W      = 16;

    //******************************************************************
    //  data types
    //******************************************************************
    // one complex fft output, real part in the upper half
    typedef struct packed {
        logic signed [15:0] re;
        logic signed [15:0] im;
    } fft_sample_t;

    // streaming fft output with framing strobes
    typedef struct packed {
        fft_sample_t sample;
        logic        sop;
        logic        eop;
        logic        valid;
    } fft_stream_t;

    // what the display gets per request
    typedef struct packed {
        logic [BIN_IDX_W-1:0] bin;
        logic [MAG_W-1:0]     mag;
    } column_t;

    //******************************************************************
    //  state encodings
    //******************************************************************
    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0, // waiting for start of frame
        CAP_FILL = 2'd1, // writing the first half frame
        CAP_HOLD = 2'd2  // buffer frozen until drained
    } capture_state_e;

    typedef enum logic [1:0] {
        SRV_IDLE = 2'd0,
        SRV_READ = 2'd1, // buffer read in flight
        SRV_CALC = 2'd2, // magnitude being registered
        SRV_ACK  = 2'd3  // column out, waiting for req to drop
    } server_state_e;

endpackage

`default_nettype wire

// File: source/bin_buffer.sv
/*
 * bin buffer
 * half frame sample store, one write port and one registered read port
 */
`timescale 1ns/100ps
`default_nettype none

module bin_buffer (
    input  logic                               clk_50m,
    input  logic                               wr_en,
    input  logic [spectrum_pkg::BIN_IDX_W-1:0] wr_addr,
    input  spectrum_pkg::fft_sample_t          wr_data,
    input  logic [spectrum_pkg::BIN_IDX_W-1:0] rd_addr,
    output spectrum_pkg::fft_sample_t          rd_data
);
    import spectrum_pkg::*;

    fft_sample_t mem [0:HALF_BINS-1];

    // write side, driven by the capture
    always_ff @(posedge clk_50m) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read side, one cycle latency
    always_ff @(posedge clk_50m) begin
        rd_data <= mem[rd_addr]; // old data on same-address collision
    end

endmodule

`default_nettype wire

// File: source/fft_frame_capture.sv
/*
 * fft frame capture
 * writes the first half of each accepted frame into the bin buffer, then holds
 */
`timescale 1ns/100ps
`default_nettype none

module fft_frame_capture (
    input  logic                               clk_50m,
    input  logic                               rst_n,
    input  spectrum_pkg::fft_stream_t          fft_in,
    input  logic                               frame_done,
    output logic                               wr_en,
    output logic [spectrum_pkg::BIN_IDX_W-1:0] wr_addr,
    output spectrum_pkg::fft_sample_t          wr_data,
    output logic                               frame_ready
);
    import spectrum_pkg::*;

    capture_state_e       state;
    logic                 valid_r;
    logic                 eop_r;
    fft_sample_t          sample_r;
    logic [BIN_IDX_W-1:0] wr_cnt;
    logic                 last_write;

    //******************************************************************
    //  input register stage
    //******************************************************************
    // strobes need a defined value out of reset
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            eop_r   <= 1'b0;
        end else begin
            valid_r <= fft_in.valid;
            eop_r   <= fft_in.eop;
        end
    end

    always_ff @(posedge clk_50m) begin
        sample_r <= fft_in.sample;
    end

    //******************************************************************
    //  buffer write port
    //******************************************************************
    assign wr_en      = (state == CAP_FILL) && valid_r;
    assign wr_addr    = wr_cnt;
    assign wr_data    = sample_r;
    assign last_write = wr_en && (wr_cnt == BIN_IDX_W'(HALF_BINS - 1));

    assign frame_ready = (state == CAP_HOLD); // half frame sitting in the buffer

    //******************************************************************
    //  capture FSM
    //******************************************************************
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state  <= CAP_IDLE;
            wr_cnt <= '0;
        end else begin
            case (state)
                CAP_IDLE: begin
                    // sample carried with sop is bin 0, written next edge
                    if (fft_in.valid && fft_in.sop) begin
                        state  <= CAP_FILL;
                        wr_cnt <= '0;
                    end
                end

                CAP_FILL: begin
                    if (last_write) begin
                        state  <= CAP_HOLD;
                        wr_cnt <= '0;
                    end else if (valid_r && eop_r) begin
                        // short frame, drop it and wait for the next one
                        state  <= CAP_IDLE;
                        wr_cnt <= '0;
                    end else if (wr_en) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                end

                CAP_HOLD: begin
                    if (frame_done) begin   // display read every column
                        state <= CAP_IDLE;
                    end
                end

                default: begin
                    state <= CAP_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/column_server.sv
/*
 * column server
 * answers display requests over a four-phase req/ack with bin index and magnitude
 */
`timescale 1ns/100ps
`default_nettype none

module column_server (
    input  logic                               clk_50m,
    input  logic                               rst_n,
    input  logic                               frame_ready,
    input  logic                               col_req,
    input  spectrum_pkg::fft_sample_t          rd_data,
    output logic [spectrum_pkg::BIN_IDX_W-1:0] rd_addr,
    output logic                               col_ack,
    output spectrum_pkg::column_t              column,
    output logic                               frame_done
);
    import spectrum_pkg::*;

    server_state_e        state;
    logic [BIN_IDX_W-1:0] bin_cnt;
    logic [MAG_W:0]       mag_sum;
    logic [MAG_W-1:0]     mag_sat;
    logic [MAG_W-1:0]     mag_r;
    logic                 last_bin;
    logic                 start;

    // |x| as unsigned, -32768 comes out as 32768
    function automatic logic [MAG_W-1:0] abs_part(input logic signed [15:0] x);
        logic [MAG_W-1:0] result;
        if (x[15]) begin
            result = MAG_W'(-x);
        end else begin
            result = MAG_W'(x);
        end
        return result;
    endfunction

    //******************************************************************
    //  magnitude
    //******************************************************************
    assign mag_sum = {1'b0, abs_part(rd_data.re)} + {1'b0, abs_part(rd_data.im)};
    assign mag_sat = mag_sum[MAG_W] ? {MAG_W{1'b1}} : mag_sum[MAG_W-1:0]; // clip at max

    always_ff @(posedge clk_50m) begin
        if (state == SRV_CALC) begin
            mag_r <= mag_sat;
        end
    end

    assign last_bin = (bin_cnt == BIN_IDX_W'(HALF_BINS - 1));

    // no new request in the cycle the capture is being released
    assign start = col_req && frame_ready && !frame_done;

    //******************************************************************
    //  handshake FSM
    //******************************************************************
    always_ff @(posedge clk_50m or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SRV_IDLE;
            bin_cnt    <= '0;
            rd_addr    <= '0;
            col_ack    <= 1'b0;
            column     <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0; // single cycle pulse

            case (state)
                SRV_IDLE: begin
                    if (start) begin
                        rd_addr <= bin_cnt;
                        state   <= SRV_READ;
                    end
                end

                SRV_READ: begin
                    state <= SRV_CALC;  // rd_data valid next cycle
                end

                SRV_CALC: begin
                    state <= SRV_ACK;
                end

                SRV_ACK: begin
                    if (!col_ack) begin
                        // column stays put until the next ack rises
                        column  <= '{bin: rd_addr, mag: mag_r};
                        col_ack <= 1'b1;
                    end else if (!col_req) begin
                        col_ack    <= 1'b0;
                        frame_done <= last_bin;
                        bin_cnt    <= bin_cnt + 1'b1;   // wraps after 127
                        state      <= SRV_IDLE;
                    end
                end

                default: begin
                    state <= SRV_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/spectrum_top.sv
/*
 * spectrum column server top
 * frame capture, bin buffer and display column server on one clock
 */
`timescale 1ns/100ps
`default_nettype none

module spectrum_top (
    input  logic                      clk_50m,
    input  logic                      rst_n,
    input  spectrum_pkg::fft_stream_t fft_in,
    input  logic                      col_req,
    output logic                      col_ack,
    output spectrum_pkg::column_t     column,
    output logic                      frame_ready
);
    import spectrum_pkg::*;

    logic                 wr_en;
    logic [BIN_IDX_W-1:0] wr_addr;
    fft_sample_t          wr_data;
    logic [BIN_IDX_W-1:0] rd_addr;
    fft_sample_t          rd_data;
    logic                 frame_done;

    //******************************************************************
    //  capture side
    //******************************************************************
    fft_frame_capture fft_frame_capture_inst (
        .clk_50m     (clk_50m),
        .rst_n       (rst_n),
        .fft_in      (fft_in),
        .frame_done  (frame_done),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .frame_ready (frame_ready)
    );

    bin_buffer bin_buffer_inst (
        .clk_50m (clk_50m),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    //******************************************************************
    //  display side
    //******************************************************************
    column_server column_server_inst (
        .clk_50m     (clk_50m),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .col_req     (col_req),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .col_ack     (col_ack),
        .column      (column),
        .frame_done  (frame_done)   // releases the capture
    );

endmodule

`default_nettype wire

// File: test/spectrum_top_assert.sv
/*
 * spectrum column server assertions
 * four-phase handshake rules and capture hold
 */
`timescale 1ns/100ps
`default_nettype none

module spectrum_top_assert (
    input  logic                         clk_50m,
    input  logic                         rst_n,
    input  logic                         col_req,
    input  logic                         col_ack,
    input  spectrum_pkg::column_t        column,
    input  logic                         frame_done,
    input  spectrum_pkg::capture_state_e cap_state
);
    import spectrum_pkg::*;

    int fail_count = 0;    // failures so far, watched by the testbench

    // ack may only rise while the display is asking
    ack_needs_req: assert property (@(posedge clk_50m) disable iff (!rst_n)
        $rose(col_ack) |-> col_req)
        else begin
            fail_count++;
            $error("col_ack rose while col_req was low");
        end

    // column only moves when a new ack rises
    column_stable: assert property (@(posedge clk_50m) disable iff (!rst_n)
        !$rose(col_ack) |-> $stable(column))
        else begin
            fail_count++;
            $error("column changed without a new col_ack");
        end

    // buffer frozen until the display drains it
    hold_until_done: assert property (@(posedge clk_50m) disable iff (!rst_n)
        ((cap_state == CAP_HOLD) && !frame_done) |=> (cap_state == CAP_HOLD))
        else begin
            fail_count++;
            $error("capture left CAP_HOLD without frame_done");
        end

endmodule

// unused side of each instance tied off
bind column_server spectrum_top_assert server_assert_inst (
    .clk_50m (clk_50m), .rst_n (rst_n), .col_req (col_req), .col_ack (col_ack),
    .column (column), .frame_done (1'b0), .cap_state (spectrum_pkg::CAP_IDLE)
);

bind fft_frame_capture spectrum_top_assert capture_assert_inst (
    .clk_50m (clk_50m), .rst_n (rst_n), .col_req (1'b0), .col_ack (1'b0),
    .column ('0), .frame_done (frame_done), .cap_state (state)
);

`default_nettype wire

// File: test/tb_spectrum_top.sv
/*
 * spectrum column server testbench
 * table-driven fft frames, four-phase column reads, magnitude checks
 */
`timescale 1ns/100ps
`default_nettype none

module tb_spectrum_top;
    import spectrum_pkg::*;

    // one row of the frame table
    typedef struct packed {
        int base_re;
        int base_im;
        int step;
        bit random_data;    // random samples, valid gaps, slow display
    } frame_row_t;

    localparam int NUM_ROWS    = 4;
    localparam int CYCLE_LIMIT = NUM_ROWS * (FFT_LENGTH + HALF_BINS * 8)
                               + NUM_ROWS * 2 * FFT_LENGTH + 2000;

    logic        clk_50m;
    logic        rst_n;
    fft_stream_t fft_in;
    logic        col_req;
    logic        col_ack;
    column_t     column;
    logic        frame_ready;

    frame_row_t  frame_table [NUM_ROWS];
    fft_sample_t frame_data [FFT_LENGTH];
    fft_sample_t model_sample [HALF_BINS];  // what the buffer should hold

    spectrum_top spectrum_top_inst (
        .clk_50m     (clk_50m),
        .rst_n       (rst_n),
        .fft_in      (fft_in),
        .col_req     (col_req),
        .col_ack     (col_ack),
        .column      (column),
        .frame_ready (frame_ready)
    );

    initial begin
        clk_50m = 1'b0;
        forever #10 clk_50m = ~clk_50m;
    end

    //**********************************************************************
    //  helpers
    //**********************************************************************
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0d expected %0d",
                     $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // failures flagged so far by the bound assertion instances
    function automatic int assertion_failures();
        return spectrum_top_inst.column_server_inst.server_assert_inst.fail_count
             + spectrum_top_inst.fft_frame_capture_inst.capture_assert_inst.fail_count;
    endfunction

    // min(|re| + |im|, 65535)
    function automatic int expected_magnitude(input fft_sample_t s);
        int a_re;
        int a_im;
        int total;
        a_re = s.re;
        a_im = s.im;
        if (a_re < 0) begin
            a_re = -a_re;
        end
        if (a_im < 0) begin
            a_im = -a_im;
        end
        total = a_re + a_im;
        if (total > 65535) begin
            total = 65535;
        end
        return total;
    endfunction

    task automatic build_frame(input frame_row_t row);
        for (int n = 0; n < FFT_LENGTH; n++) begin
            if (row.random_data) begin
                frame_data[n].re = 16'($urandom);
                frame_data[n].im = 16'($urandom);
            end else begin
                frame_data[n].re = 16'(row.base_re + n * row.step);
                frame_data[n].im = 16'(row.base_im - n * row.step);
            end
            if (n < HALF_BINS) begin
                model_sample[n] = frame_data[n];
            end
        end
    endtask

    // decoy frames carry a pattern unrelated to the table
    task automatic send_frame(input logic with_gaps, input logic decoy);
        fft_stream_t beat;
        int          gap;
        for (int n = 0; n < FFT_LENGTH; n++) begin
            gap = 0;
            if (with_gaps && ($urandom % 4 == 0)) begin
                gap = 1 + $urandom % 2;
            end
            repeat (gap) begin
                @(posedge clk_50m);
                fft_in <= '0;   // valid low between beats
            end
            beat = '0;
            beat.sample = decoy ? {16'(n * 97 - 9000), 16'(4000 - n * 53)} : frame_data[n];
            beat.sop    = (n == 0);
            beat.eop    = (n == FFT_LENGTH - 1);
            beat.valid  = 1'b1;
            @(posedge clk_50m);
            fft_in <= beat;
        end
        @(posedge clk_50m);
        fft_in <= '0;
    endtask

    task automatic raise_request();
        @(posedge clk_50m);
        col_req <= 1'b1;
    endtask

    // waits for ack, checks the column, then closes the handshake
    task automatic finish_column(input int bin, input logic slow);
        int hold_cycles;
        do @(negedge clk_50m); while (col_ack !== 1'b1);
        check_value(frame_ready, 1, "ack without a captured frame");
        check_value(column.bin, bin, "column bin index");
        check_value(column.mag, expected_magnitude(model_sample[bin]), "column magnitude");
        hold_cycles = slow ? $urandom % 4 : 0;
        repeat (hold_cycles) @(posedge clk_50m);
        @(posedge clk_50m);
        col_req <= 1'b0;
        do @(negedge clk_50m); while (col_ack !== 1'b0);
    endtask

    //**********************************************************************
    //  main sequence
    //**********************************************************************
    initial begin
        int first_bin;
        void'($urandom(32'h105));
        rst_n       = 1'b0;
        col_req     = 1'b0;
        fft_in      = '0;

        frame_table[0] = '{base_re: -2000, base_im: 1500, step: 37, random_data: 1'b0};
        frame_table[1] = '{base_re: -32768, base_im: -32768, step: 0, random_data: 1'b0};
        frame_table[2] = '{base_re: 0, base_im: 0, step: 0, random_data: 1'b1};
        frame_table[3] = '{base_re: 12345, base_im: -23456, step: -211, random_data: 1'b0};

        repeat (10) @(posedge clk_50m);
        rst_n <= 1'b1;
        @(negedge clk_50m);
        check_value(col_ack, 0, "col_ack after reset");
        check_value(frame_ready, 0, "frame_ready after reset");

        for (int r = 0; r < NUM_ROWS; r++) begin
            build_frame(frame_table[r]);
            first_bin = 0;
            if (r == 0) begin
                // request with an empty buffer must stall
                raise_request();
                repeat (20) begin
                    @(negedge clk_50m);
                    check_value(col_ack, 0, "ack before any frame");
                end
            end
            send_frame(frame_table[r].random_data, 1'b0);
            @(negedge clk_50m);
            check_value(frame_ready, 1, "frame_ready after full frame");
            send_frame(1'b0, 1'b1);     // arrives while held, must be dropped
            if (r == 0) begin
                finish_column(0, 1'b0);
                first_bin = 1;
            end
            for (int b = first_bin; b < HALF_BINS; b++) begin
                raise_request();
                finish_column(b, frame_table[r].random_data);
            end
            repeat (2) @(negedge clk_50m);
            check_value(frame_ready, 0, "frame_ready after last column");
        end

        if (assertion_failures() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d bound assertion failures", assertion_failures());
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

    // a failed handshake or capture assertion ends the run
    always @(negedge clk_50m) begin
        if (assertion_failures() != 0) begin
            $display("ERROR: a bound assertion on the handshake or capture failed");
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // watchdog
    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk_50m);
            cycle_count++;
        end
        $display("ERROR: run timed out after %0d clock cycles", cycle_count);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: filelist.f
source/spectrum_pkg.sv
source/bin_buffer.sv
source/fft_frame_capture.sv
source/column_server.sv
source/spectrum_top.sv
test/spectrum_top_assert.sv
test/tb_spectrum_top.sv

// File: Bender.yml
package:
  name: spectrum_column_server

sources:
  # package first, then RTL
  - source/spectrum_pkg.sv
  - source/bin_buffer.sv
  - source/fft_frame_capture.sv
  - source/column_server.sv
  - source/spectrum_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/spectrum_top_assert.sv
      - test/tb_spectrum_top.sv
